/* bit_width_converter.sv */
`default_nettype none
`timescale 1ns/1ns

module bit_width_converter import bwc_pkg::*; (
    input  wire logic                      CLK,
    input  wire logic                      RST_N,
    input  wire logic                      flush,     // Clears count, last and cache
    input  wire logic [IN_BW_W-1:0]        in_bw,     // Valid bits per input word
    input  wire logic [OUT_BW_W-1:0]       out_bw,    // Valid bits per output word
    input  wire logic                      in_vld,
    input  wire logic                      in_last,
    input  wire logic [DATA_IN_WIDTH-1:0]  in_dat,
    output logic                           in_rdy,
    output logic [DATA_OUT_WIDTH-1:0]      conv_dat,
    output logic                           conv_vld,
    output logic                           conv_last,
    output logic [OUT_BW_W-1:0]            conv_cnt,
    input  wire logic                      conv_rdy
);

    // ========================================
    // Packing state
    // ========================================
    logic [CNT_W-1:0]          count;     // Valid bits held in cache
    logic                      last_q;    // Last input word of packet taken
    logic [CACHE_WIDTH-1:0]    cache;     // LSB-first bit stream, zero above count

    logic                      take;      // Input transfer this cycle
    logic                      drain;     // Output transfer this cycle
    logic [CNT_W-1:0]          fill;      // Count plus one input word
    logic [CNT_W-1:0]          drain_cnt; // Bits removed by this cycle's drain
    logic [CNT_W-1:0]          base_cnt;  // Count after the drain
    logic [CACHE_WIDTH-1:0]    base;      // Cache after the drain
    logic [CACHE_WIDTH-1:0]    in_mask;   // Low in_bw ones
    logic [CACHE_WIDTH-1:0]    in_ext;    // Masked input at bit 0
    logic [DATA_OUT_WIDTH-1:0] out_mask;  // Low out_bw ones

    // ========================================
    // Output side
    // ========================================
    // A word is ready once out_bw bits are held, or the tail once the packet ended
    assign conv_vld  = (count != '0) && ((count >= CNT_W'(out_bw)) || last_q);
    assign conv_cnt  = (count < CNT_W'(out_bw)) ? count[OUT_BW_W-1:0] : out_bw; // Short tail
    assign conv_last = last_q && (count <= CNT_W'(out_bw));                   // Final word
    assign out_mask  = ~({DATA_OUT_WIDTH{1'b1}} << out_bw);
    assign conv_dat  = cache[DATA_OUT_WIDTH-1:0] & out_mask; // Zero above out_bw

    assign drain     = conv_vld & conv_rdy;
    assign drain_cnt = drain ? CNT_W'(conv_cnt) : '0;
    assign base_cnt  = count - drain_cnt;
    assign base      = cache >> drain_cnt; // Right shift, zeros fill the top

    // ========================================
    // Input side
    // ========================================
    assign fill    = count + CNT_W'(in_bw);
    // Room now, or room once the pending word leaves in this same cycle
    assign in_rdy  = !last_q &&
                     ((fill <= CNT_W'(CACHE_WIDTH)) ||
                      (drain && (fill <= CNT_W'(CACHE_WIDTH) + drain_cnt)));
    assign take    = in_vld & in_rdy;
    assign in_mask = ~({CACHE_WIDTH{1'b1}} << in_bw);
    assign in_ext  = {{(CACHE_WIDTH-DATA_IN_WIDTH){1'b0}}, in_dat} & in_mask;

    // Count and packet-end flag
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            count  <= '0;
            last_q <= 1'b0;
        end else if (flush) begin
            count  <= '0;          // New packet starts empty
            last_q <= 1'b0;
        end else begin
            if (take) begin
                count  <= base_cnt + CNT_W'(in_bw);
                last_q <= in_last;
            end else if (drain) begin
                count  <= base_cnt;
            end
        end
    end

    // Packing register
    always_ff @(posedge CLK) begin
        if (flush) begin
            cache <= '0;            // Keeps bits above count at zero
        end else if (take) begin
            cache <= base | (in_ext << base_cnt); // Append at fill position
        end else if (drain) begin
            cache <= base;
        end
    end

endmodule

`default_nettype wire

/* bwc_assertions.sv */
`default_nettype none
`timescale 1ns/1ns

module bwc_assertions import bwc_pkg::*; (
    input  wire logic                      CLK,
    input  wire logic                      RST_N,
    input  wire logic                      busy,
    input  wire logic                      in_rdy,
    input  wire logic                      out_vld,
    input  wire logic                      out_rdy,
    input  wire logic                      out_last,
    input  wire logic [DATA_OUT_WIDTH-1:0] out_dat,
    input  wire logic [OUT_BW_W-1:0]       out_cnt,
    input  wire logic [OUT_BW_W-1:0]       out_bw,  // Latched output width
    input  wire ctrl_state_t               state    // Control FSM state
);

    int unsigned fail_cnt; // Failed assertions read by the testbench

    initial fail_cnt = 0;

    // ========================================
    // Output handshake
    // ========================================
    a_out_hold: assert property (@(posedge CLK) disable iff (!RST_N)
        out_vld && !out_rdy |=> out_vld && $stable(out_dat))
        else begin
            $error("Output word dropped or changed while stalled");
            fail_cnt++;
        end

    a_out_cnt: assert property (@(posedge CLK) disable iff (!RST_N)
        out_vld |-> (out_cnt != '0) && (out_cnt <= out_bw))
        else begin
            $error("out_cnt outside 1..out_bw");
            fail_cnt++;
        end

    a_last_vld: assert property (@(posedge CLK) disable iff (!RST_N)
        out_last |-> out_vld)
        else begin
            $error("out_last without out_vld");
            fail_cnt++;
        end

    // ========================================
    // Control
    // ========================================
    a_idle_rdy: assert property (@(posedge CLK) disable iff (!RST_N)
        !busy |-> !in_rdy)
        else begin
            $error("in_rdy high while idle");
            fail_cnt++;
        end

    a_run_out: assert property (@(posedge CLK) disable iff (!RST_N)
        (state != CTRL_RUN) |-> !out_vld)
        else begin
            $error("Output word outside a running packet");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* bwc_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns

module bwc_ctrl import bwc_pkg::*; (
    input  wire logic                CLK,
    input  wire logic                RST_N,
    input  wire logic                cfg_load,    // Width load strobe
    input  wire logic [IN_BW_W-1:0]  cfg_in_bw,
    input  wire logic [OUT_BW_W-1:0] cfg_out_bw,
    input  wire logic                conv_in_rdy, // Converter has room
    input  wire logic                in_vld_ext,  // Producer valid
    input  wire logic                out_vld,     // Top-level output handshake
    input  wire logic                out_rdy,
    input  wire logic                out_last,
    output logic [IN_BW_W-1:0]       in_bw,
    output logic [OUT_BW_W-1:0]      out_bw,
    output logic                     flush,
    output logic                     busy,
    output logic                     cfg_err,
    output logic                     in_vld_int,  // Valid seen by converter
    output logic                     in_rdy       // Ready seen by producer
);

    ctrl_state_t state;
    logic        legal; // Both widths in range
    logic        run;   // Input window open
    logic        done;  // Final output word accepted

    assign legal = (cfg_in_bw != '0) && (cfg_in_bw <= IN_BW_W'(DATA_IN_WIDTH)) &&
                   (cfg_out_bw != '0) && (cfg_out_bw <= OUT_BW_W'(DATA_OUT_WIDTH));
    assign done  = out_vld & out_rdy & out_last;

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state   <= CTRL_IDLE;
            in_bw   <= '0;
            out_bw  <= '0;
            cfg_err <= 1'b0;
        end else begin
            cfg_err <= 1'b0;                     // Single-cycle pulse
            case (state)
                CTRL_IDLE: begin
                    if (cfg_load && legal) begin
                        in_bw  <= cfg_in_bw;     // Held for the whole packet
                        out_bw <= cfg_out_bw;
                        state  <= CTRL_FLUSH;
                    end else if (cfg_load) begin
                        cfg_err <= 1'b1;         // Rejected, state unchanged
                    end
                end
                CTRL_FLUSH: state <= CTRL_RUN;
                CTRL_RUN: begin
                    if (done) begin
                        state <= CTRL_IDLE;      // Packet fully delivered
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    assign flush      = (state == CTRL_FLUSH);
    assign busy       = (state != CTRL_IDLE);
    assign run        = (state == CTRL_RUN);
    assign in_vld_int = in_vld_ext & run;  // Nothing enters during flush
    assign in_rdy     = conv_in_rdy & run;

endmodule

`default_nettype wire

/* bwc_pkg.sv */
`default_nettype none

package bwc_pkg;

    // ========================================
    // Bus and register widths
    // ========================================
    localparam int DATA_IN_WIDTH  = 64;                             // Input word bus
    localparam int DATA_OUT_WIDTH = 128;                            // Output word bus
    localparam int CACHE_WIDTH    = DATA_IN_WIDTH + DATA_OUT_WIDTH; // Packing register size

    // ========================================
    // Width-field sizes
    // ========================================
    localparam int IN_BW_W  = $clog2(DATA_IN_WIDTH) + 1;  // Holds 0..64
    localparam int OUT_BW_W = $clog2(DATA_OUT_WIDTH) + 1; // Holds 0..128
    localparam int CNT_W    = $clog2(CACHE_WIDTH) + 1;    // Fill count 0..CACHE_WIDTH

    // ========================================
    // Control FSM
    // ========================================
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0, // Waiting for a width load
        CTRL_FLUSH = 2'd1, // One-cycle converter clear
        CTRL_RUN   = 2'd2  // Packet in flight
    } ctrl_state_t;

endpackage

`default_nettype wire

/* bwc_top.f */
bwc_pkg.sv
bit_width_converter.sv
bwc_ctrl.sv
out_skid_buffer.sv
bwc_top.sv
bwc_assertions.sv
tb_bwc_top.sv

/* bwc_top.sv */
`default_nettype none
`timescale 1ns/1ns

module bwc_top import bwc_pkg::*; (
    input  wire logic                      CLK,
    input  wire logic                      RST_N,
    input  wire logic                      cfg_load,
    input  wire logic [IN_BW_W-1:0]        cfg_in_bw,
    input  wire logic [OUT_BW_W-1:0]       cfg_out_bw,
    output logic                           busy,
    output logic                           cfg_err,
    input  wire logic                      in_vld,
    input  wire logic                      in_last,
    input  wire logic [DATA_IN_WIDTH-1:0]  in_dat,
    output logic                           in_rdy,
    output logic [DATA_OUT_WIDTH-1:0]      out_dat,
    output logic                           out_vld,
    output logic                           out_last,
    output logic [OUT_BW_W-1:0]            out_cnt,
    input  wire logic                      out_rdy
);

    // ========================================
    // Internal nets
    // ========================================
    logic [IN_BW_W-1:0]        in_bw;       // Latched widths
    logic [OUT_BW_W-1:0]       out_bw;
    logic                      flush;
    logic                      in_vld_int;  // Gated producer valid
    logic                      conv_in_rdy; // Ungated converter ready
    logic                      conv_vld;
    logic [DATA_OUT_WIDTH-1:0] conv_dat;
    logic                      conv_last;
    logic [OUT_BW_W-1:0]       conv_cnt;
    logic                      conv_rdy;

    bwc_ctrl u_ctrl (
        .CLK(CLK), .RST_N(RST_N),
        .cfg_load(cfg_load), .cfg_in_bw(cfg_in_bw), .cfg_out_bw(cfg_out_bw),
        .conv_in_rdy(conv_in_rdy), .in_vld_ext(in_vld),
        .out_vld(out_vld), .out_rdy(out_rdy), .out_last(out_last),
        .in_bw(in_bw), .out_bw(out_bw), .flush(flush), .busy(busy),
        .cfg_err(cfg_err), .in_vld_int(in_vld_int), .in_rdy(in_rdy)
    );

    bit_width_converter u_conv (
        .CLK(CLK), .RST_N(RST_N), .flush(flush),
        .in_bw(in_bw), .out_bw(out_bw),
        .in_vld(in_vld_int), .in_last(in_last), .in_dat(in_dat), .in_rdy(conv_in_rdy),
        .conv_dat(conv_dat), .conv_vld(conv_vld), .conv_last(conv_last),
        .conv_cnt(conv_cnt), .conv_rdy(conv_rdy)
    );

    // Registered output stage, cuts out_rdy off the input ready path
    out_skid_buffer u_skid (
        .CLK(CLK), .RST_N(RST_N), .flush(flush),
        .conv_vld(conv_vld), .conv_dat(conv_dat), .conv_last(conv_last),
        .conv_cnt(conv_cnt), .conv_rdy(conv_rdy),
        .out_vld(out_vld), .out_dat(out_dat), .out_last(out_last),
        .out_cnt(out_cnt), .out_rdy(out_rdy)
    );

endmodule

`default_nettype wire

/* out_skid_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

module out_skid_buffer import bwc_pkg::*; (
    input  wire logic                      CLK,
    input  wire logic                      RST_N,
    input  wire logic                      flush,     // Drops both entries
    input  wire logic                      conv_vld,
    input  wire logic [DATA_OUT_WIDTH-1:0] conv_dat,
    input  wire logic                      conv_last,
    input  wire logic [OUT_BW_W-1:0]       conv_cnt,
    output logic                           conv_rdy,
    output logic                           out_vld,
    output logic [DATA_OUT_WIDTH-1:0]      out_dat,
    output logic                           out_last,
    output logic [OUT_BW_W-1:0]            out_cnt,
    input  wire logic                      out_rdy
);

    // ========================================
    // Entries
    // ========================================
    logic                      main_vld;  // Entry on the outputs
    logic                      main_last;
    logic                      skid_vld;  // Overflow entry
    logic [DATA_OUT_WIDTH-1:0] skid_dat;
    logic                      skid_last;
    logic [OUT_BW_W-1:0]       skid_cnt;

    logic                      push;      // Converter transfer
    logic                      pop;       // Outside transfer
    logic                      load_main; // Main entry free this cycle

    assign conv_rdy  = ~skid_vld;         // Flop output, under two entries held
    assign push      = conv_vld & conv_rdy;
    assign pop       = main_vld & out_rdy;
    assign load_main = ~main_vld | pop;

    // Valid flags
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            main_vld  <= 1'b0;
            main_last <= 1'b0;
            skid_vld  <= 1'b0;
        end else if (flush) begin
            main_vld  <= 1'b0;
            main_last <= 1'b0;
            skid_vld  <= 1'b0;
        end else if (load_main) begin
            main_vld  <= skid_vld | push;       // Skid first, keeps order
            main_last <= skid_vld ? skid_last : (push & conv_last);
            skid_vld  <= 1'b0;
        end else if (push) begin
            skid_vld  <= 1'b1;                  // Main stalled, park the word
        end
    end

    // Payload
    always_ff @(posedge CLK) begin
        if (load_main) begin
            out_dat <= skid_vld ? skid_dat : conv_dat;
            out_cnt <= skid_vld ? skid_cnt : conv_cnt;
        end
        if (!load_main && push) begin
            skid_dat  <= conv_dat;
            skid_last <= conv_last;
            skid_cnt  <= conv_cnt;
        end
    end

    assign out_vld  = main_vld;
    assign out_last = main_last;

endmodule

`default_nettype wire

/* tb_bwc_top.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_bwc_top import bwc_pkg::*; ();

    // ========================================
    // Run length and limits
    // ========================================
    localparam int NUM_PKTS   = 20;
    localparam int MAX_WORDS  = 24;
    localparam int TIMEOUT_NS = NUM_PKTS * MAX_WORDS * 16 * 4 + 50000; // Budget plus margin

    logic                      CLK;
    logic                      RST_N;
    logic                      cfg_load;
    logic [IN_BW_W-1:0]        cfg_in_bw;
    logic [OUT_BW_W-1:0]       cfg_out_bw;
    logic                      busy;
    logic                      cfg_err;
    logic                      in_vld;
    logic                      in_last;
    logic [DATA_IN_WIDTH-1:0]  in_dat;
    logic                      in_rdy;
    logic [DATA_OUT_WIDTH-1:0] out_dat;
    logic                      out_vld;
    logic                      out_last;
    logic [OUT_BW_W-1:0]       out_cnt;
    logic                      out_rdy;

    logic [15:0] lfsr;      // Random source state
    bit          bitq[$];   // Reference stream in LSB-first order
    int          errors;    // Failed checks
    int          words_out; // Output words seen

    bwc_top bwc_top_i (
        .CLK(CLK), .RST_N(RST_N),
        .cfg_load(cfg_load), .cfg_in_bw(cfg_in_bw), .cfg_out_bw(cfg_out_bw),
        .busy(busy), .cfg_err(cfg_err),
        .in_vld(in_vld), .in_last(in_last), .in_dat(in_dat), .in_rdy(in_rdy),
        .out_dat(out_dat), .out_vld(out_vld), .out_last(out_last),
        .out_cnt(out_cnt), .out_rdy(out_rdy)
    );

    bind bwc_top bwc_assertions asrt_i (
        .CLK(CLK), .RST_N(RST_N), .busy(busy), .in_rdy(in_rdy),
        .out_vld(out_vld), .out_rdy(out_rdy), .out_last(out_last),
        .out_dat(out_dat), .out_cnt(out_cnt), .out_bw(out_bw), .state(u_ctrl.state)
    );

    always #2 CLK = ~CLK; // 4 ns period

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) r[i] = lfsr_step(); // One step per bit
        return r;
    endfunction

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0t ns: %s got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    // Illegal width load must be refused
    task automatic try_bad_cfg();
        logic [1:0] kind;
        kind       = rand_bits(2);
        cfg_in_bw  = IN_BW_W'(1 + rand_bits(6));
        cfg_out_bw = OUT_BW_W'(1 + rand_bits(7));
        case (kind)
            2'd0: cfg_in_bw  = '0;
            2'd1: cfg_in_bw  = IN_BW_W'(65 + rand_bits(5));   // Above input bus
            2'd2: cfg_out_bw = '0;
            default: cfg_out_bw = OUT_BW_W'(129 + rand_bits(6)); // Above output bus
        endcase
        cfg_load = 1'b1;
        in_vld   = 1'b1;                                      // Offered data must not enter
        @(posedge CLK); #1;
        cfg_load = 1'b0;
        @(posedge CLK);
        check(cfg_err, 1'b1, "cfg_err after illegal load");
        check(busy, 1'b0, "busy after illegal load");
        check(in_rdy, 1'b0, "in_rdy after illegal load");
        @(posedge CLK);
        check(cfg_err, 1'b0, "cfg_err pulse length");
        check(busy, 1'b0, "busy stays low");
        #1;
        in_vld = 1'b0;
    endtask

    // One legal packet from load to final output word
    task automatic run_packet();
        int           ib, ob, nw, sent, total, cnt_sum, exp_cnt, i;
        logic         done, took, exp_last;
        logic [127:0] exp_word;
        ib = int'(rand_bits(6)) + 1;
        ob = int'(rand_bits(7)) + 1;
        nw = int'(rand_bits(5)) % MAX_WORDS + 1;
        sent    = 0;
        total   = 0;
        cnt_sum = 0;
        done    = 1'b0;
        cfg_in_bw  = IN_BW_W'(ib);
        cfg_out_bw = OUT_BW_W'(ob);
        cfg_load   = 1'b1;
        @(posedge CLK); #1;
        cfg_load   = 1'b0;
        cfg_in_bw  = IN_BW_W'(rand_bits(7));  // Junk while the latched widths hold
        cfg_out_bw = OUT_BW_W'(rand_bits(8));
        while (!done) begin
            @(posedge CLK);
            check(busy, 1'b1, "busy during packet");
            took = in_vld && in_rdy;
            if (out_vld && out_rdy) begin     // Output first since its bits entered earlier
                exp_last = (sent == nw) && (bitq.size() <= ob);
                exp_cnt  = exp_last ? bitq.size() : ob;
                exp_word = '0;
                for (i = 0; i < exp_cnt && bitq.size() > 0; i++) exp_word[i] = bitq.pop_front();
                check(out_dat, exp_word, "out_dat");
                check(out_cnt, exp_cnt, "out_cnt");
                check(out_last, exp_last, "out_last");
                cnt_sum += out_cnt;
                words_out++;
                if (out_last) begin
                    done = 1'b1;
                    check(out_cnt, (total % ob == 0) ? ob : total % ob, "final word count");
                end
            end
            if (took) begin
                for (i = 0; i < ib; i++) bitq.push_back(in_dat[i]); // Low ib bits only
                sent++;
                total += ib;
            end
            #1;
            if (took || !in_vld) begin        // Hold the offer until taken
                if (sent < nw && rand_bits(2) != 0) begin
                    in_vld  = 1'b1;
                    in_dat  = rand_bits(64);
                    in_last = (sent == nw - 1);
                end else begin
                    in_vld  = 1'b0;
                    in_last = 1'b0;
                end
            end
            out_rdy = (rand_bits(2) != 0);    // Ready 3 cycles in 4
        end
        in_vld  = 1'b0;
        in_last = 1'b0;
        @(posedge CLK);
        check(busy, 1'b0, "busy after final word");
        check(out_vld, 1'b0, "out_vld after final word");
        check(bitq.size(), 0, "model bits left over");
        check(cnt_sum, total, "output bits vs input bits");
        #1;
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int pkt;
        lfsr       = 16'd15228;
        errors     = 0;
        words_out  = 0;
        CLK        = 1'b0;
        RST_N      = 1'b0;
        cfg_load   = 1'b0;
        cfg_in_bw  = '0;
        cfg_out_bw = '0;
        in_vld     = 1'b0;
        in_last    = 1'b0;
        in_dat     = '0;
        out_rdy    = 1'b0;
        repeat (4) @(posedge CLK);
        #1 RST_N = 1'b1;
        @(posedge CLK);
        check(busy, 1'b0, "busy after reset");
        check(in_rdy, 1'b0, "in_rdy after reset");
        check(out_vld, 1'b0, "out_vld after reset");
        #1;
        for (pkt = 0; pkt < NUM_PKTS; pkt++) begin
            if (pkt % 4 == 0) try_bad_cfg();
            run_packet();
        end
        $display("Run done: %0d packets, %0d words, %0d check errors, %0d assertion errors",
                 NUM_PKTS, words_out, errors, bwc_top_i.asrt_i.fail_cnt);
        if (errors == 0 && bwc_top_i.asrt_i.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns, %0d check errors so far",
                 TIMEOUT_NS, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
